/* hw/render_pkg.sv */
`default_nettype none

package render_pkg;

	// Font geometry
	localparam int FONT_W      = 8;
	localparam int FONT_H      = 8;
	localparam int FONT_LINE_W = 3;

	// Data widths
	localparam int CHAR_W     = 8;
	localparam int COLOR_W    = 3;
	localparam int PIX_SIZE_W = 3;

	// Counter and text memory address widths
	localparam int POS_W      = 11;
	localparam int COL_ADDR_W = 6;
	localparam int ROW_ADDR_W = 5;

	localparam logic [COLOR_W-1:0] C_BLACK = 3'b000;

endpackage

`default_nettype wire

/* hw/scan_counter.sv */
`default_nettype none

module scan_counter #(
	parameter int H_ACTIVE  = 640,
	parameter int H_FRONT   = 16,
	parameter int H_SYNC    = 96,
	parameter int H_BACK    = 48,
	parameter int V_ACTIVE  = 480,
	parameter int V_FRONT   = 10,
	parameter int V_SYNC    = 2,
	parameter int V_BACK    = 33,
	parameter int TEXT_COLS = 64,
	parameter int TEXT_ROWS = 32
) (
	input  logic                                                      clk,
	input  logic                                                      rst_n,
	input  logic [render_pkg::PIX_SIZE_W-1:0]                         pix_w,
	input  logic [render_pkg::PIX_SIZE_W-1:0]                         pix_h,
	input  logic [render_pkg::ROW_ADDR_W-1:0]                         selected_row,
	output logic [render_pkg::COL_ADDR_W+render_pkg::ROW_ADDR_W-1:0] text_addr,
	output logic                                                      active,
	output logic                                                      in_grid,
	output logic                                                      selected,
	output logic                                                      spacing,
	output logic [$clog2(render_pkg::FONT_W+1)-1:0]                   font_col,
	output logic [render_pkg::FONT_LINE_W-1:0]                        font_line,
	output logic                                                      hsync,
	output logic                                                      vsync
);
	import render_pkg::*;

	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int VS_START = V_ACTIVE + V_FRONT;
	localparam int FCOL_W   = $clog2(FONT_W + 1);
	localparam int FLINE_W  = $clog2(FONT_H + 1);

	logic [POS_W-1:0]      h_pos;
	logic [POS_W-1:0]      v_pos;
	logic [PIX_SIZE_W-1:0] h_sub;
	logic [PIX_SIZE_W-1:0] v_sub;
	logic [FCOL_W-1:0]     h_font;
	logic [FLINE_W-1:0]    v_font;
	logic [POS_W-1:0]      h_cell;
	logic [POS_W-1:0]      v_cell;
	logic [PIX_SIZE_W-1:0] pix_w_q;
	logic [PIX_SIZE_W-1:0] pix_h_q;
	logic                  line_end;
	logic                  frame_end;

	assign line_end  = (h_pos == POS_W'(H_TOTAL - 1));
	assign frame_end = line_end && (v_pos == POS_W'(V_TOTAL - 1));

	// Scale is frozen for a whole frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_w_q <= PIX_SIZE_W'(1);
			pix_h_q <= PIX_SIZE_W'(1);
		end else if (frame_end) begin
			pix_w_q <= pix_w;
			pix_h_q <= pix_h;
		end
	end

	// Horizontal position, sub-pixel, font column, cell column
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			h_pos  <= '0;
			h_sub  <= '0;
			h_font <= '0;
			h_cell <= '0;
		end else if (line_end) begin
			h_pos  <= '0;
			h_sub  <= '0;
			h_font <= '0;
			h_cell <= '0;
		end else begin
			h_pos <= h_pos + 1'b1;
			if (h_sub == pix_w_q - 1'b1) begin
				h_sub <= '0;
				// Glyph columns plus one spacing column
				if (h_font == FCOL_W'(FONT_W)) begin
					h_font <= '0;
					h_cell <= h_cell + 1'b1;
				end else begin
					h_font <= h_font + 1'b1;
				end
			end else begin
				h_sub <= h_sub + 1'b1;
			end
		end
	end

	// Vertical set steps once per line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v_pos  <= '0;
			v_sub  <= '0;
			v_font <= '0;
			v_cell <= '0;
		end else if (frame_end) begin
			v_pos  <= '0;
			v_sub  <= '0;
			v_font <= '0;
			v_cell <= '0;
		end else if (line_end) begin
			v_pos <= v_pos + 1'b1;
			if (v_sub == pix_h_q - 1'b1) begin
				v_sub <= '0;
				if (v_font == FLINE_W'(FONT_H)) begin
					v_font <= '0;
					v_cell <= v_cell + 1'b1;
				end else begin
					v_font <= v_font + 1'b1;
				end
			end else begin
				v_sub <= v_sub + 1'b1;
			end
		end
	end

	assign active   = (h_pos < POS_W'(H_ACTIVE)) && (v_pos < POS_W'(V_ACTIVE));
	assign hsync    = (h_pos >= POS_W'(HS_START)) && (h_pos < POS_W'(HS_START + H_SYNC));
	assign vsync    = (v_pos >= POS_W'(VS_START)) && (v_pos < POS_W'(VS_START + V_SYNC));
	assign in_grid  = (h_cell < POS_W'(TEXT_COLS)) && (v_cell < POS_W'(TEXT_ROWS));
	assign selected = (v_cell == POS_W'(selected_row));
	assign spacing  = (h_font == FCOL_W'(FONT_W)) || (v_font == FLINE_W'(FONT_H));

	assign font_col  = h_font;
	assign font_line = v_font[FONT_LINE_W-1:0];

	// Row in the upper bits, column in the lower
	assign text_addr = {v_cell[ROW_ADDR_W-1:0], h_cell[COL_ADDR_W-1:0]};

	a_scale_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		frame_end |-> (pix_w != '0) && (pix_h != '0));

	a_hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(hsync) |-> hsync [*H_SYNC] ##1 !hsync);

endmodule

`default_nettype wire

/* hw/attr_delay.sv */
`default_nettype none

module attr_delay (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    active,
	input  logic                                    in_grid,
	input  logic                                    selected,
	input  logic                                    spacing,
	input  logic [$clog2(render_pkg::FONT_W+1)-1:0] font_col,
	input  logic [render_pkg::FONT_LINE_W-1:0]      font_line,
	input  logic                                    hsync,
	input  logic                                    vsync,
	output logic [render_pkg::FONT_LINE_W-1:0]      font_line_d1,
	output logic                                    active_d2,
	output logic                                    in_grid_d2,
	output logic                                    selected_d2,
	output logic                                    spacing_d2,
	output logic [$clog2(render_pkg::FONT_W+1)-1:0] font_col_d2,
	output logic                                    hsync_d2,
	output logic                                    vsync_d2
);
	import render_pkg::*;

	localparam int FCOL_W = $clog2(FONT_W + 1);

	logic              active_d1;
	logic              in_grid_d1;
	logic              selected_d1;
	logic              spacing_d1;
	logic [FCOL_W-1:0] font_col_d1;
	logic              hsync_d1;
	logic              vsync_d1;

	// Stage 1 lines up with the text memory read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active_d1    <= 1'b0;
			in_grid_d1   <= 1'b0;
			selected_d1  <= 1'b0;
			spacing_d1   <= 1'b0;
			font_col_d1  <= '0;
			font_line_d1 <= '0;
			hsync_d1     <= 1'b0;
			vsync_d1     <= 1'b0;
		end else begin
			active_d1    <= active;
			in_grid_d1   <= in_grid;
			selected_d1  <= selected;
			spacing_d1   <= spacing;
			font_col_d1  <= font_col;
			font_line_d1 <= font_line;
			hsync_d1     <= hsync;
			vsync_d1     <= vsync;
		end
	end

	// Stage 2 lines up with the font memory read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active_d2   <= 1'b0;
			in_grid_d2  <= 1'b0;
			selected_d2 <= 1'b0;
			spacing_d2  <= 1'b0;
			font_col_d2 <= '0;
			hsync_d2    <= 1'b0;
			vsync_d2    <= 1'b0;
		end else begin
			active_d2   <= active_d1;
			in_grid_d2  <= in_grid_d1;
			selected_d2 <= selected_d1;
			spacing_d2  <= spacing_d1;
			font_col_d2 <= font_col_d1;
			hsync_d2    <= hsync_d1;
			vsync_d2    <= vsync_d1;
		end
	end

endmodule

`default_nettype wire

/* hw/pixel_shader.sv */
`default_nettype none

module pixel_shader (
	input  logic                                                clk,
	input  logic                                                rst_n,
	input  logic [render_pkg::CHAR_W-1:0]                       text_q,
	input  logic [render_pkg::FONT_W-1:0]                       font_q,
	input  logic [render_pkg::FONT_LINE_W-1:0]                  font_line_d1,
	input  logic                                                active_d2,
	input  logic                                                in_grid_d2,
	input  logic                                                selected_d2,
	input  logic                                                spacing_d2,
	input  logic [$clog2(render_pkg::FONT_W+1)-1:0]             font_col_d2,
	input  logic                                                hsync_d2,
	input  logic                                                vsync_d2,
	input  logic [render_pkg::COLOR_W-1:0]                      fg,
	input  logic [render_pkg::COLOR_W-1:0]                      bg,
	input  logic [render_pkg::COLOR_W-1:0]                      sel_fg,
	input  logic [render_pkg::COLOR_W-1:0]                      sel_bg,
	output logic [render_pkg::CHAR_W+render_pkg::FONT_LINE_W-1:0] font_addr,
	output logic [render_pkg::COLOR_W-1:0]                      rgb,
	output logic                                                hsync_out,
	output logic                                                vsync_out
);
	import render_pkg::*;

	localparam int ADDR_W = CHAR_W + FONT_LINE_W;
	localparam int BIT_W  = $clog2(FONT_W);

	logic [BIT_W-1:0]   bit_sel;
	logic               glyph_on;
	logic               use_sel;
	logic [COLOR_W-1:0] pix_color;

	// One glyph row per font address
	assign font_addr = ADDR_W'(text_q) * ADDR_W'(FONT_H) + ADDR_W'(font_line_d1);

	// Leftmost pixel is the MSB of the row
	assign bit_sel  = BIT_W'(FONT_W - 1) - font_col_d2[BIT_W-1:0];
	assign glyph_on = in_grid_d2 && !spacing_d2 && font_q[bit_sel];

	// Selection only colours cells inside the grid
	assign use_sel = selected_d2 && in_grid_d2;

	always_comb begin
		if (!active_d2) begin
			pix_color = C_BLACK;
		end else if (glyph_on) begin
			pix_color = use_sel ? sel_fg : fg;
		end else begin
			pix_color = use_sel ? sel_bg : bg;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rgb       <= C_BLACK;
			hsync_out <= 1'b0;
			vsync_out <= 1'b0;
		end else begin
			rgb       <= pix_color;
			hsync_out <= hsync_d2;
			vsync_out <= vsync_d2;
		end
	end

	// Sync pulses lie in blanking so the pins go out black with them
	a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
		(hsync_d2 || vsync_d2) |=> (rgb == C_BLACK));

endmodule

`default_nettype wire

/* hw/text_renderer.sv */
`default_nettype none

module text_renderer #(
	parameter int H_ACTIVE  = 640,
	parameter int H_FRONT   = 16,
	parameter int H_SYNC    = 96,
	parameter int H_BACK    = 48,
	parameter int V_ACTIVE  = 480,
	parameter int V_FRONT   = 10,
	parameter int V_SYNC    = 2,
	parameter int V_BACK    = 33,
	parameter int TEXT_COLS = 64,
	parameter int TEXT_ROWS = 32
) (
	input  logic                                                      clk,
	input  logic                                                      rst_n,
	output logic [render_pkg::COL_ADDR_W+render_pkg::ROW_ADDR_W-1:0] text_addr,
	input  logic [render_pkg::CHAR_W-1:0]                             text_q,
	output logic [render_pkg::CHAR_W+render_pkg::FONT_LINE_W-1:0]    font_addr,
	input  logic [render_pkg::FONT_W-1:0]                             font_q,
	input  logic [render_pkg::PIX_SIZE_W-1:0]                         pix_w,
	input  logic [render_pkg::PIX_SIZE_W-1:0]                         pix_h,
	input  logic [render_pkg::ROW_ADDR_W-1:0]                         selected_row,
	input  logic [render_pkg::COLOR_W-1:0]                            fg,
	input  logic [render_pkg::COLOR_W-1:0]                            bg,
	input  logic [render_pkg::COLOR_W-1:0]                            sel_fg,
	input  logic [render_pkg::COLOR_W-1:0]                            sel_bg,
	output logic [render_pkg::COLOR_W-1:0]                            RGB,
	output logic                                                      HSYNC,
	output logic                                                      VSYNC
);
	import render_pkg::*;

	localparam int FCOL_W = $clog2(FONT_W + 1);

	// Attributes of the scan position at address issue
	logic                   active;
	logic                   in_grid;
	logic                   selected;
	logic                   spacing;
	logic [FCOL_W-1:0]      font_col;
	logic [FONT_LINE_W-1:0] font_line;
	logic                   hsync;
	logic                   vsync;

	// Delayed copies
	logic [FONT_LINE_W-1:0] font_line_d1;
	logic                   active_d2;
	logic                   in_grid_d2;
	logic                   selected_d2;
	logic                   spacing_d2;
	logic [FCOL_W-1:0]      font_col_d2;
	logic                   hsync_d2;
	logic                   vsync_d2;

	scan_counter #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.TEXT_COLS(TEXT_COLS), .TEXT_ROWS(TEXT_ROWS)
	) u_scan (
		.clk(clk), .rst_n(rst_n), .pix_w(pix_w), .pix_h(pix_h),
		.selected_row(selected_row), .text_addr(text_addr),
		.active(active), .in_grid(in_grid), .selected(selected), .spacing(spacing),
		.font_col(font_col), .font_line(font_line), .hsync(hsync), .vsync(vsync)
	);

	attr_delay u_delay (
		.clk(clk), .rst_n(rst_n),
		.active(active), .in_grid(in_grid), .selected(selected), .spacing(spacing),
		.font_col(font_col), .font_line(font_line), .hsync(hsync), .vsync(vsync),
		.font_line_d1(font_line_d1), .active_d2(active_d2), .in_grid_d2(in_grid_d2),
		.selected_d2(selected_d2), .spacing_d2(spacing_d2), .font_col_d2(font_col_d2),
		.hsync_d2(hsync_d2), .vsync_d2(vsync_d2)
	);

	pixel_shader u_shader (
		.clk(clk), .rst_n(rst_n), .text_q(text_q), .font_q(font_q),
		.font_line_d1(font_line_d1), .active_d2(active_d2), .in_grid_d2(in_grid_d2),
		.selected_d2(selected_d2), .spacing_d2(spacing_d2), .font_col_d2(font_col_d2),
		.hsync_d2(hsync_d2), .vsync_d2(vsync_d2),
		.fg(fg), .bg(bg), .sel_fg(sel_fg), .sel_bg(sel_bg),
		.font_addr(font_addr), .rgb(RGB), .hsync_out(HSYNC), .vsync_out(VSYNC)
	);

endmodule

`default_nettype wire

/* dv/tb_text_renderer.sv */
`default_nettype none

module tb_text_renderer;
	timeunit 1ns;
	timeprecision 100ps;
	import render_pkg::*;

	localparam int H_ACTIVE     = 80;
	localparam int H_FRONT      = 4;
	localparam int H_SYNC       = 6;
	localparam int H_BACK       = 6;
	localparam int V_ACTIVE     = 40;
	localparam int V_FRONT      = 2;
	localparam int V_SYNC       = 2;
	localparam int V_BACK       = 3;
	localparam int TEXT_COLS    = 6;
	localparam int TEXT_ROWS    = 3;
	localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HS_START     = H_ACTIVE + H_FRONT;
	localparam int VS_START     = V_ACTIVE + V_FRONT;
	localparam int PIPE_LATENCY = 3;
	localparam int FADDR_W      = CHAR_W + FONT_LINE_W;
	localparam int MEM_DEPTH    = 2048;
	// Five frames plus reset and slack
	localparam int WATCHDOG_CYCLES = 5 * H_TOTAL * V_TOTAL + 8 + 500;
	localparam logic [31:0] LFSR_SEED = 32'h518a_68a5;

	logic                             clk;
	logic                             rst_n;
	logic [COL_ADDR_W+ROW_ADDR_W-1:0] text_addr;
	logic [CHAR_W-1:0]                text_q = '0;
	logic [FADDR_W-1:0]               font_addr;
	logic [FONT_W-1:0]                font_q = '0;
	logic [PIX_SIZE_W-1:0]            pix_w;
	logic [PIX_SIZE_W-1:0]            pix_h;
	logic [ROW_ADDR_W-1:0]            selected_row;
	logic [COLOR_W-1:0]               fg;
	logic [COLOR_W-1:0]               bg;
	logic [COLOR_W-1:0]               sel_fg;
	logic [COLOR_W-1:0]               sel_bg;
	logic [COLOR_W-1:0]               RGB;
	logic                             HSYNC;
	logic                             VSYNC;

	logic [CHAR_W-1:0] text_mem [MEM_DEPTH];
	logic [FONT_W-1:0] font_mem [MEM_DEPTH];
	logic [31:0]       lfsr;

	// Position of the pixel currently on the outputs
	int                h_m;
	int                v_m;
	int                cur_h;
	int                cur_v;
	int                next_h;
	int                next_v;
	int                scale_w;
	int                scale_h;
	int                next_sw;
	int                next_sh;
	int                hs_len;
	int                hs_gap;
	int                vs_len;
	int                rst_cycles;
	int                checked_pixels;
	logic              hs_q;
	logic              vs_q;
	logic              h_ok;
	logic              v_ok;
	logic              pos_ok;
	logic              exp_active;
	logic [COLOR_W-1:0] exp_rgb;

	text_renderer #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.TEXT_COLS(TEXT_COLS), .TEXT_ROWS(TEXT_ROWS)
	) DUT (.*);

	// Both memories answer one cycle after the address
	always @(posedge clk) begin
		text_q <= text_mem[text_addr];
		font_q <= font_mem[font_addr];
	end

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	task automatic fill_memories();
		int a;
		int b;
		lfsr = LFSR_SEED;
		for (a = 0; a < MEM_DEPTH; a++) begin
			for (b = 0; b < CHAR_W; b++) begin
				lfsr = lfsr_step(lfsr);
				text_mem[FADDR_W'(a)][3'(b)] = lfsr[0];
			end
		end
		for (a = 0; a < MEM_DEPTH; a++) begin
			for (b = 0; b < FONT_W; b++) begin
				lfsr = lfsr_step(lfsr);
				font_mem[FADDR_W'(a)][3'(b)] = lfsr[0];
			end
		end
	endtask

	function automatic logic [COLOR_W-1:0] pixel_colour(input int h, input int v,
			input int sw, input int sh, input int sel);
		int                col;
		int                row;
		int                fcol;
		int                fline;
		logic              in_grid;
		logic              on_sel;
		logic              glyph_bit;
		logic [CHAR_W-1:0] code;
		logic [FONT_W-1:0] glyph;
		if (h >= H_ACTIVE || v >= V_ACTIVE) begin
			return C_BLACK;
		end
		// Cell is one font pixel wider and one line taller than the glyph
		col = h / ((FONT_W + 1) * sw);
		fcol = (h % ((FONT_W + 1) * sw)) / sw;
		row = v / ((FONT_H + 1) * sh);
		fline = (v % ((FONT_H + 1) * sh)) / sh;
		in_grid = (col < TEXT_COLS) && (row < TEXT_ROWS);
		on_sel = in_grid && (row == sel);
		glyph_bit = 1'b0;
		if (in_grid && fcol < FONT_W && fline < FONT_H) begin
			code = text_mem[{row[ROW_ADDR_W-1:0], col[COL_ADDR_W-1:0]}];
			glyph = font_mem[FADDR_W'(code) * FADDR_W'(FONT_H) + FADDR_W'(fline)];
			glyph_bit = glyph[3'(FONT_W - 1 - fcol)];
		end
		if (glyph_bit) begin
			return on_sel ? sel_fg : fg;
		end
		return on_sel ? sel_bg : bg;
	endfunction

	// Realign on sync rising edges, otherwise step through the frame
	always_comb begin
		cur_h = h_m;
		cur_v = v_m;
		if (VSYNC && !vs_q) begin
			cur_h = 0;
			cur_v = VS_START;
		end else if (HSYNC && !hs_q) begin
			cur_h = HS_START;
		end
		next_h = (cur_h == H_TOTAL - 1) ? 0 : cur_h + 1;
		next_v = cur_v;
		if (cur_h == H_TOTAL - 1) begin
			next_v = (cur_v == V_TOTAL - 1) ? 0 : cur_v + 1;
		end
		next_sw = scale_w;
		next_sh = scale_h;
		if (next_h == 0 && next_v == 0) begin
			next_sw = int'(pix_w);
			next_sh = int'(pix_h);
		end
	end

	assign pos_ok = h_ok && v_ok;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			h_m            <= 0;
			v_m            <= 0;
			scale_w        <= 1;
			scale_h        <= 1;
			hs_len         <= 0;
			hs_gap         <= 0;
			vs_len         <= 0;
			rst_cycles     <= 0;
			checked_pixels <= 0;
			hs_q           <= 1'b0;
			vs_q           <= 1'b0;
			h_ok           <= 1'b0;
			v_ok           <= 1'b0;
			exp_active     <= 1'b0;
			exp_rgb        <= C_BLACK;
		end else begin
			hs_q    <= HSYNC;
			vs_q    <= VSYNC;
			h_m     <= next_h;
			v_m     <= next_v;
			scale_w <= next_sw;
			scale_h <= next_sh;
			if (HSYNC && !hs_q) begin
				h_ok <= 1'b1;
			end
			if (VSYNC && !vs_q) begin
				v_ok <= 1'b1;
			end
			hs_len <= HSYNC ? hs_len + 1 : 0;
			vs_len <= VSYNC ? vs_len + 1 : 0;
			hs_gap <= (HSYNC && !hs_q) ? 1 : hs_gap + 1;
			if (rst_cycles < PIPE_LATENCY) begin
				rst_cycles <= rst_cycles + 1;
			end
			if (pos_ok && exp_active) begin
				checked_pixels <= checked_pixels + 1;
			end
			exp_active <= (next_h < H_ACTIVE) && (next_v < V_ACTIVE);
			exp_rgb    <= pixel_colour(next_h, next_v, next_sw, next_sh, int'(selected_row));
		end
	end

	task automatic stop_on_failure();
		$display("tests failed");
		$fatal(1, "simulation stopped after a failure");
	endtask

	a_hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(HSYNC) |-> (hs_len == H_SYNC))
		else begin
			$display("CHECK FAILED at %0t: HSYNC high for %0d cycles, expected %0d",
				$time, $sampled(hs_len), H_SYNC);
			stop_on_failure();
		end

	a_hsync_period: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(HSYNC) && h_ok |-> (hs_gap == H_TOTAL))
		else begin
			$display("CHECK FAILED at %0t: HSYNC period %0d cycles, expected %0d",
				$time, $sampled(hs_gap), H_TOTAL);
			stop_on_failure();
		end

	a_vsync_width: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(VSYNC) |-> (vs_len == V_SYNC * H_TOTAL))
		else begin
			$display("CHECK FAILED at %0t: VSYNC high for %0d cycles, expected %0d",
				$time, $sampled(vs_len), V_SYNC * H_TOTAL);
			stop_on_failure();
		end

	// Pipeline is still empty for the first cycles after reset
	a_reset_black: assert property (@(posedge clk)
		(rst_cycles < PIPE_LATENCY) |-> (RGB == C_BLACK))
		else begin
			$display("CHECK FAILED at %0t: RGB %0d right after reset, expected 0",
				$time, $sampled(RGB));
			stop_on_failure();
		end

	a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
		pos_ok && !exp_active |-> (RGB == C_BLACK))
		else begin
			$display("CHECK FAILED at %0t: RGB %0d in blanking at (%0d,%0d)",
				$time, $sampled(RGB), $sampled(h_m), $sampled(v_m));
			stop_on_failure();
		end

	a_pixel_colour: assert property (@(posedge clk) disable iff (!rst_n)
		pos_ok && exp_active |-> (RGB == exp_rgb))
		else begin
			$display("CHECK FAILED at %0t: RGB %0d at (%0d,%0d), expected %0d",
				$time, $sampled(RGB), $sampled(h_m), $sampled(v_m), $sampled(exp_rgb));
			stop_on_failure();
		end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic wait_vsync_rise();
		@(posedge VSYNC);
		@(posedge clk);
	endtask

	initial begin
		rst_n = 1'b0;
		pix_w = 3'd1;
		pix_h = 3'd1;
		// Row 31 lies outside the grid
		selected_row = 5'd31;
		fg = 3'd2;
		bg = 3'd5;
		sel_fg = 3'd6;
		sel_bg = 3'd3;
		fill_memories();
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		// First VSYNC aligns the model, the next one ends a fully checked frame
		wait_vsync_rise();
		wait_vsync_rise();
		selected_row <= 5'd1;
		wait_vsync_rise();
		pix_w <= 3'd2;
		pix_h <= 3'd3;
		wait_vsync_rise();
		if (checked_pixels > 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("No active pixel reached the colour checks");
			stop_on_failure();
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		stop_on_failure();
	end

endmodule

`default_nettype wire

/* project.f */
hw/render_pkg.sv
hw/scan_counter.sv
hw/attr_delay.sv
hw/pixel_shader.sv
hw/text_renderer.sv
dv/tb_text_renderer.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_text_renderer -f project.f -o tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "RESULT: FAIL (build)"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && echo "RESULT: FAIL" && exit 1
grep -q "all tests passed" sim.log && echo "RESULT: PASS" && exit 0
echo "RESULT: FAIL (no result in log)"
exit 1
